/* axi_wr_downsizer_params.svh */
/*
 * Write downsizer parameters
 * Bus widths and AXI protocol limits shared by the packages and the RTL
 */

`ifndef AXI_WR_DOWNSIZER_PARAMS_SVH
`define AXI_WR_DOWNSIZER_PARAMS_SVH

// Address and ID widths
`define DW_ADDR_WIDTH 32
`define DW_ID_WIDTH 4

// Wide slave port and narrow master port
`define DW_SI_DATA_WIDTH 64
`define DW_MI_DATA_WIDTH 32

// Largest value of the AXI length field
`define DW_MAX_BURST_LEN 255

// Cache bit that allows a burst to be resized
`define DW_CACHE_MODIFIABLE 4'b0010

`endif

/* axi_proto_pkg.sv */
/*
 * AXI protocol types
 * Field types and burst encodings used on both sides of the downsizer
 */

`default_nettype none

`include "axi_wr_downsizer_params.svh"

package axi_proto_pkg;

  // Address phase fields
  typedef logic [`DW_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`DW_ID_WIDTH-1:0]   id_t;
  typedef logic [7:0]                len_t;
  typedef logic [2:0]                size_t;
  typedef logic [3:0]                cache_t;
  typedef logic [1:0]                resp_t;

  // Data phase on each side
  typedef logic [`DW_SI_DATA_WIDTH-1:0]   si_data_t;
  typedef logic [`DW_SI_DATA_WIDTH/8-1:0] si_strb_t;
  typedef logic [`DW_MI_DATA_WIDTH-1:0]   mi_data_t;
  typedef logic [`DW_MI_DATA_WIDTH/8-1:0] mi_strb_t;

  // Burst type encoding
  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } burst_e;

endpackage

`default_nettype wire

/* dw_ctrl_pkg.sv */
/*
 * Downsizer control types
 * Conversion mode and the length of a whole downsized burst
 */

`default_nettype none

`include "axi_wr_downsizer_params.svh"

package dw_ctrl_pkg;

  // Narrow beat count minus one, up to 256 wide beats times the ratio
  typedef logic [$clog2(`DW_SI_DATA_WIDTH / `DW_MI_DATA_WIDTH) + 7:0] full_len_t;

  // How the current write is converted
  typedef enum logic [1:0] {
    MODE_IDLE           = 2'd0,
    MODE_PASSTHROUGH    = 2'd1,
    MODE_INCR_DOWNSIZE  = 2'd2,
    MODE_SPLIT_DOWNSIZE = 2'd3
  } dw_mode_e;

endpackage

`default_nettype wire

/* aw_planner.sv */
/*
 * AW planner
 * Decodes a wide AW command into a downsizing plan: conversion mode,
 * total narrow length, length of the first slave burst and slave size
 */

`default_nettype none

`include "axi_wr_downsizer_params.svh"

module aw_planner (
  input  axi_proto_pkg::addr_t   slv_aw_addr_i,
  input  axi_proto_pkg::len_t    slv_aw_len_i,
  input  axi_proto_pkg::size_t   slv_aw_size_i,
  input  axi_proto_pkg::burst_e  slv_aw_burst_i,
  input  axi_proto_pkg::cache_t  slv_aw_cache_i,
  output dw_ctrl_pkg::dw_mode_e  plan_mode_o,
  output dw_ctrl_pkg::full_len_t plan_total_len_o,
  output axi_proto_pkg::len_t    plan_first_len_o,
  output axi_proto_pkg::size_t   plan_size_o
);

  import axi_proto_pkg::*;
  import dw_ctrl_pkg::*;

  localparam int unsigned mi_bytes = `DW_MI_DATA_WIDTH / 8;
  localparam size_t       mi_size  = size_t'($clog2(mi_bytes));

  logic        downsize;
  addr_t       size_mask;
  int unsigned ratio;
  int unsigned align_adj;
  int unsigned total_len;

  // Only modifiable INCR bursts wider than the narrow bus get resized
  assign downsize = (|(slv_aw_cache_i & `DW_CACHE_MODIFIABLE)) &&
                    (slv_aw_burst_i == BURST_INCR) &&
                    (slv_aw_size_i > mi_size);

  // --------------------
  // Length arithmetic
  // --------------------

  always_comb begin
    size_mask = (addr_t'(1) << slv_aw_size_i) - addr_t'(1);
    ratio     = (32'd1 << slv_aw_size_i) / mi_bytes;
    // Narrow beats skipped in front of an unaligned start
    align_adj = (slv_aw_addr_i & size_mask) >> mi_size;
    total_len = (32'(slv_aw_len_i) + 32'd1) * ratio - align_adj - 32'd1;

    if (downsize) begin
      plan_size_o      = mi_size;
      plan_total_len_o = full_len_t'(total_len);
      if (total_len <= `DW_MAX_BURST_LEN) begin
        plan_mode_o      = MODE_INCR_DOWNSIZE;
        plan_first_len_o = len_t'(total_len);
      end else begin
        // First slave burst ends on a 256-beat boundary of the wide burst
        plan_mode_o      = MODE_SPLIT_DOWNSIZE;
        plan_first_len_o = len_t'(`DW_MAX_BURST_LEN - align_adj);
      end
    end else begin
      plan_mode_o      = MODE_PASSTHROUGH;
      plan_total_len_o = full_len_t'(slv_aw_len_i);
      plan_first_len_o = slv_aw_len_i;
      plan_size_o      = slv_aw_size_i;
    end
  end

endmodule

`default_nettype wire

/* w_lane_steer.sv */
/*
 * W lane steering
 * Holds the conversion mode, beat counters and current address of the
 * write in flight, maps wide W bytes onto narrow lanes with zero latency
 * and requests a new slave AW when a split burst ends
 */

`default_nettype none

`include "axi_wr_downsizer_params.svh"

module w_lane_steer (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    aw_accept_i,
  input  dw_ctrl_pkg::dw_mode_e   plan_mode_i,
  input  dw_ctrl_pkg::full_len_t  plan_total_len_i,
  input  axi_proto_pkg::len_t     plan_first_len_i,
  input  axi_proto_pkg::size_t    plan_size_i,
  input  axi_proto_pkg::addr_t    slv_aw_addr_i,
  input  axi_proto_pkg::size_t    slv_aw_size_i,
  input  logic                    aw_pending_i,
  output logic                    idle_o,
  output logic                    reissue_o,
  output axi_proto_pkg::len_t     reissue_len_o,
  output axi_proto_pkg::addr_t    reissue_addr_o,
  input  axi_proto_pkg::si_data_t slv_w_data_i,
  input  axi_proto_pkg::si_strb_t slv_w_strb_i,
  input  logic                    slv_w_last_i,
  input  logic                    slv_w_valid_i,
  output logic                    slv_w_ready_o,
  output axi_proto_pkg::mi_data_t mst_w_data_o,
  output axi_proto_pkg::mi_strb_t mst_w_strb_o,
  output logic                    mst_w_last_o,
  output logic                    mst_w_valid_o,
  input  logic                    mst_w_ready_i
);

  import axi_proto_pkg::*;
  import dw_ctrl_pkg::*;

  localparam int unsigned si_bytes = `DW_SI_DATA_WIDTH / 8;
  localparam int unsigned mi_bytes = `DW_MI_DATA_WIDTH / 8;

  dw_mode_e  mode_q;
  full_len_t total_q;
  len_t      burst_q;
  addr_t     addr_q;
  size_t     size_q;
  size_t     wsize_q;

  logic      beat;
  logic      word_done;
  addr_t     size_mask;
  addr_t     wide_mask;
  addr_t     next_addr;
  full_len_t total_next;

  assign idle_o = (mode_q == MODE_IDLE);

  // W flows only once the slave holds the matching AW
  assign mst_w_valid_o = !idle_o && !aw_pending_i && slv_w_valid_i;
  assign beat          = mst_w_valid_o && mst_w_ready_i;

  // --------------------
  // Address stepping
  // --------------------

  assign size_mask  = (addr_t'(1) << size_q) - addr_t'(1);
  assign wide_mask  = (addr_t'(1) << wsize_q) - addr_t'(1);
  assign next_addr  = (addr_q & ~size_mask) + (addr_t'(1) << size_q);
  assign total_next = total_q - full_len_t'(1);

  // Wide word is used up when the next narrow address leaves it
  assign word_done = (total_q == '0) ||
                     ((next_addr & ~wide_mask) != (addr_q & ~wide_mask));

  assign slv_w_ready_o = beat && ((mode_q == MODE_PASSTHROUGH) || word_done);

  // End of every slave burst, the final one follows the wide last
  assign mst_w_last_o = (burst_q == '0) && (slv_w_last_i || (total_q != '0));

  // Split burst boundary with beats still to go
  assign reissue_o      = beat && (mode_q == MODE_SPLIT_DOWNSIZE) &&
                          (burst_q == '0) && (total_q != '0);
  assign reissue_len_o  = (total_next > full_len_t'(`DW_MAX_BURST_LEN)) ?
                          len_t'(`DW_MAX_BURST_LEN) : len_t'(total_next);
  assign reissue_addr_o = next_addr;

  // --------------------
  // Lane steering
  // --------------------

  always_comb begin
    int si_off;
    int mi_off;
    int lane;
    si_off       = int'(addr_q[$clog2(si_bytes)-1:0]);
    mi_off       = int'(addr_q[$clog2(mi_bytes)-1:0]);
    lane         = 0;
    mst_w_data_o = '0;
    mst_w_strb_o = '0;
    for (int b = 0; b < int'(si_bytes); b++) begin
      lane = b + mi_off - si_off;
      // Bytes inside the slave-size window that starts at the wide offset
      if ((b >= si_off) && ((b - si_off) < (1 << size_q)) && (lane < int'(mi_bytes))) begin
        mst_w_data_o[8*lane +: 8] = slv_w_data_i[8*b +: 8];
        mst_w_strb_o[lane]        = slv_w_strb_i[b];
      end
    end
  end

  // --------------------
  // State
  // --------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q  <= MODE_IDLE;
      total_q <= '0;
      burst_q <= '0;
    end else if (aw_accept_i) begin
      mode_q  <= plan_mode_i;
      total_q <= plan_total_len_i;
      burst_q <= plan_first_len_i;
    end else if (beat) begin
      total_q <= total_next;
      burst_q <= reissue_o ? reissue_len_o : burst_q - len_t'(1);
      if (total_q == '0) begin
        mode_q <= MODE_IDLE;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_accept_i) begin
      addr_q  <= slv_aw_addr_i;
      size_q  <= plan_size_i;
      wsize_q <= slv_aw_size_i;
    end else if (beat) begin
      addr_q <= next_addr;
    end
  end

  // --------------------
  // Assertions
  // --------------------

  // Wide last has to line up with the planned narrow length
  a_last_at_end : assert property (@(posedge clk_i) disable iff (!rst_ni)
    beat && (total_q == '0) |-> slv_w_last_i)
    else $error("final narrow beat without the wide last");

  a_no_early_last : assert property (@(posedge clk_i) disable iff (!rst_ni)
    slv_w_ready_o && slv_w_last_i |-> (total_q == '0))
    else $error("wide last taken before the planned length was reached");

endmodule

`default_nettype wire

/* aw_issue.sv */
/*
 * Slave AW issue
 * Registers the narrow AW command on accept or on a split re-issue and
 * holds it on the master port until the slave takes it
 */

`default_nettype none

module aw_issue (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   aw_accept_i,
  input  axi_proto_pkg::id_t     slv_aw_id_i,
  input  axi_proto_pkg::addr_t   slv_aw_addr_i,
  input  axi_proto_pkg::burst_e  slv_aw_burst_i,
  input  axi_proto_pkg::cache_t  slv_aw_cache_i,
  input  axi_proto_pkg::len_t    plan_first_len_i,
  input  axi_proto_pkg::size_t   plan_size_i,
  input  logic                   reissue_i,
  input  axi_proto_pkg::len_t    reissue_len_i,
  input  axi_proto_pkg::addr_t   reissue_addr_i,
  output axi_proto_pkg::id_t     mst_aw_id_o,
  output axi_proto_pkg::addr_t   mst_aw_addr_o,
  output axi_proto_pkg::len_t    mst_aw_len_o,
  output axi_proto_pkg::size_t   mst_aw_size_o,
  output axi_proto_pkg::burst_e  mst_aw_burst_o,
  output axi_proto_pkg::cache_t  mst_aw_cache_o,
  output logic                   mst_aw_valid_o,
  input  logic                   mst_aw_ready_i,
  output logic                   aw_pending_o
);

  // Valid from the edge after a load until the handshake
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mst_aw_valid_o <= 1'b0;
    end else if (aw_accept_i || reissue_i) begin
      mst_aw_valid_o <= 1'b1;
    end else if (mst_aw_ready_i) begin
      mst_aw_valid_o <= 1'b0;
    end
  end

  // ID, burst, cache and size stay the same across split bursts
  always_ff @(posedge clk_i) begin
    if (aw_accept_i) begin
      mst_aw_id_o    <= slv_aw_id_i;
      mst_aw_addr_o  <= slv_aw_addr_i;
      mst_aw_len_o   <= plan_first_len_i;
      mst_aw_size_o  <= plan_size_i;
      mst_aw_burst_o <= slv_aw_burst_i;
      mst_aw_cache_o <= slv_aw_cache_i;
    end else if (reissue_i) begin
      mst_aw_addr_o <= reissue_addr_i;
      mst_aw_len_o  <= reissue_len_i;
    end
  end

  assign aw_pending_o = mst_aw_valid_o;

  // Upstream must not load a new command while one is waiting
  a_aw_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    mst_aw_valid_o && !mst_aw_ready_i |=>
      mst_aw_valid_o && $stable(mst_aw_id_o) && $stable(mst_aw_addr_o) &&
      $stable(mst_aw_len_o) && $stable(mst_aw_size_o) &&
      $stable(mst_aw_burst_o) && $stable(mst_aw_cache_o))
    else $error("narrow AW changed while waiting for ready");

endmodule

`default_nettype wire

/* axi_wr_downsizer.sv */
/*
 * AXI write downsizer
 * Connects a 64-bit AXI write master to a 32-bit slave, one write at a
 * time, with long bursts split into several slave bursts
 */

`default_nettype none

module axi_wr_downsizer (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Wide side
  input  axi_proto_pkg::id_t      slv_aw_id_i,
  input  axi_proto_pkg::addr_t    slv_aw_addr_i,
  input  axi_proto_pkg::len_t     slv_aw_len_i,
  input  axi_proto_pkg::size_t    slv_aw_size_i,
  input  axi_proto_pkg::burst_e   slv_aw_burst_i,
  input  axi_proto_pkg::cache_t   slv_aw_cache_i,
  input  logic                    slv_aw_valid_i,
  output logic                    slv_aw_ready_o,
  input  axi_proto_pkg::si_data_t slv_w_data_i,
  input  axi_proto_pkg::si_strb_t slv_w_strb_i,
  input  logic                    slv_w_last_i,
  input  logic                    slv_w_valid_i,
  output logic                    slv_w_ready_o,
  output axi_proto_pkg::id_t      slv_b_id_o,
  output axi_proto_pkg::resp_t    slv_b_resp_o,
  output logic                    slv_b_valid_o,
  input  logic                    slv_b_ready_i,
  // Narrow side
  output axi_proto_pkg::id_t      mst_aw_id_o,
  output axi_proto_pkg::addr_t    mst_aw_addr_o,
  output axi_proto_pkg::len_t     mst_aw_len_o,
  output axi_proto_pkg::size_t    mst_aw_size_o,
  output axi_proto_pkg::burst_e   mst_aw_burst_o,
  output axi_proto_pkg::cache_t   mst_aw_cache_o,
  output logic                    mst_aw_valid_o,
  input  logic                    mst_aw_ready_i,
  output axi_proto_pkg::mi_data_t mst_w_data_o,
  output axi_proto_pkg::mi_strb_t mst_w_strb_o,
  output logic                    mst_w_last_o,
  output logic                    mst_w_valid_o,
  input  logic                    mst_w_ready_i,
  input  axi_proto_pkg::id_t      mst_b_id_i,
  input  axi_proto_pkg::resp_t    mst_b_resp_i,
  input  logic                    mst_b_valid_i,
  output logic                    mst_b_ready_o
);

  import axi_proto_pkg::*;
  import dw_ctrl_pkg::*;

  logic      idle;
  logic      aw_accept;
  logic      aw_pending;
  dw_mode_e  plan_mode;
  full_len_t plan_total_len;
  len_t      plan_first_len;
  size_t     plan_size;
  logic      reissue;
  len_t      reissue_len;
  addr_t     reissue_addr;

  // One write in flight, a new AW only while the W side is idle
  assign slv_aw_ready_o = idle;
  assign aw_accept      = slv_aw_valid_i && idle;

  aw_planner i_aw_planner (
    .slv_aw_addr_i   (slv_aw_addr_i),
    .slv_aw_len_i    (slv_aw_len_i),
    .slv_aw_size_i   (slv_aw_size_i),
    .slv_aw_burst_i  (slv_aw_burst_i),
    .slv_aw_cache_i  (slv_aw_cache_i),
    .plan_mode_o     (plan_mode),
    .plan_total_len_o(plan_total_len),
    .plan_first_len_o(plan_first_len),
    .plan_size_o     (plan_size)
  );

  w_lane_steer i_w_lane_steer (
    .clk_i, .rst_ni,
    .aw_accept_i     (aw_accept),
    .plan_mode_i     (plan_mode),
    .plan_total_len_i(plan_total_len),
    .plan_first_len_i(plan_first_len),
    .plan_size_i     (plan_size),
    .slv_aw_addr_i, .slv_aw_size_i,
    .aw_pending_i    (aw_pending),
    .idle_o          (idle),
    .reissue_o       (reissue),
    .reissue_len_o   (reissue_len),
    .reissue_addr_o  (reissue_addr),
    .slv_w_data_i, .slv_w_strb_i, .slv_w_last_i, .slv_w_valid_i, .slv_w_ready_o,
    .mst_w_data_o, .mst_w_strb_o, .mst_w_last_o, .mst_w_valid_o, .mst_w_ready_i
  );

  aw_issue i_aw_issue (
    .clk_i, .rst_ni,
    .aw_accept_i     (aw_accept),
    .slv_aw_id_i, .slv_aw_addr_i, .slv_aw_burst_i, .slv_aw_cache_i,
    .plan_first_len_i(plan_first_len),
    .plan_size_i     (plan_size),
    .reissue_i       (reissue),
    .reissue_len_i   (reissue_len),
    .reissue_addr_i  (reissue_addr),
    .mst_aw_id_o, .mst_aw_addr_o, .mst_aw_len_o, .mst_aw_size_o,
    .mst_aw_burst_o, .mst_aw_cache_o, .mst_aw_valid_o, .mst_aw_ready_i,
    .aw_pending_o    (aw_pending)
  );

  // B response goes straight back to the wide master
  assign slv_b_id_o    = mst_b_id_i;
  assign slv_b_resp_o  = mst_b_resp_i;
  assign slv_b_valid_o = mst_b_valid_i;
  assign mst_b_ready_o = slv_b_ready_i;

endmodule

`default_nettype wire

/* tb_axi_wr_downsizer.sv */
/*
 * Write downsizer testbench
 * Replays wide writes from the stimulus file under random narrow stalls
 * and checks narrow AW, narrow W and the B return path
 */

`default_nettype none

module tb_axi_wr_downsizer;

  timeunit 1ns;
  timeprecision 100ps;

  import axi_proto_pkg::*;

  localparam int clk_period = 40;

  typedef struct packed {
    id_t    id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_e burst;
    cache_t cache;
  } aw_cmd_t;

  logic     clk_i = 1'b0;
  logic     rst_ni;
  id_t      slv_aw_id_i, slv_b_id_o, mst_aw_id_o, mst_b_id_i;
  addr_t    slv_aw_addr_i, mst_aw_addr_o;
  len_t     slv_aw_len_i, mst_aw_len_o;
  size_t    slv_aw_size_i, mst_aw_size_o;
  burst_e   slv_aw_burst_i, mst_aw_burst_o;
  cache_t   slv_aw_cache_i, mst_aw_cache_o;
  si_data_t slv_w_data_i;
  si_strb_t slv_w_strb_i;
  mi_data_t mst_w_data_o;
  mi_strb_t mst_w_strb_o;
  resp_t    slv_b_resp_o, mst_b_resp_i;
  logic     slv_aw_valid_i, slv_aw_ready_o, mst_aw_valid_o, mst_aw_ready_i;
  logic     slv_w_last_i, slv_w_valid_i, slv_w_ready_o;
  logic     mst_w_last_o, mst_w_valid_o, mst_w_ready_i;
  logic     slv_b_valid_o, slv_b_ready_i, mst_b_valid_i, mst_b_ready_o;

  aw_cmd_t     cmd_q[$];
  logic [31:0] wbase_q[$];
  si_strb_t    wstrb_q[$];
  aw_cmd_t     exp_aw_q[$];
  // Narrow data, strobe and last of each expected beat
  logic [36:0] exp_w_q[$];
  logic [31:0] rnd = 32'hf0392aa2;
  int          errors = 0;
  int          cmd_count = 0;
  int          aw_seen = 0;
  int          w_seen = 0;
  int          b_seen = 0;
  int          b_todo = 0;
  id_t         b_id = '0;
  logic        loaded = 1'b0;
  logic        aw_hold = 1'b0;
  logic        w_hold = 1'b0;
  addr_t       held_addr;
  len_t        held_len;
  mi_data_t    held_data;

  axi_wr_downsizer i_axi_wr_downsizer (.*);

  always #(clk_period / 2) clk_i = ~clk_i;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  task automatic report_error(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
    errors++;
    $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
  endtask

  task automatic drive_aw(input aw_cmd_t cmd, input logic valid);
    slv_aw_id_i    = cmd.id;
    slv_aw_addr_i  = cmd.addr;
    slv_aw_len_i   = cmd.len;
    slv_aw_size_i  = cmd.size;
    slv_aw_burst_i = cmd.burst;
    slv_aw_cache_i = cmd.cache;
    slv_aw_valid_i = valid;
  endtask

  // --------------------
  // Stimulus file
  // --------------------

  task automatic load_stimulus();
    int          fd;
    int          n;
    int          want;
    string       line;
    logic [31:0] f[9];
    fd = $fopen("downsizer_stimulus.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("cannot open downsizer_stimulus.txt");
    end else begin
      while ($fgets(line, fd) > 0) begin
        n    = 0;
        want = 0;
        case (line[0])
          "C": begin
            want = 6;
            n = $sscanf(line, "C %h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5]);
            cmd_q.push_back({f[0][3:0], f[1], f[2][7:0], f[3][2:0], f[4][1:0], f[5][3:0]});
          end
          "W": begin
            want = 2;
            n = $sscanf(line, "W %h %h", f[0], f[1]);
            wbase_q.push_back(f[0]);
            wstrb_q.push_back(f[1][7:0]);
          end
          "A": begin
            want = 9;
            n = $sscanf(line, "A %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
            exp_aw_q.push_back({f[0][3:0], f[1], f[2][7:0], f[3][2:0], f[4][1:0], f[5][3:0]});
            for (int j = 0; j <= int'(f[2]); j++) begin
              exp_w_q.push_back({f[6] + f[7] * 32'(j), f[8][3:0], j == int'(f[2])});
            end
          end
          default: ;
        endcase
        if (n != want) begin
          errors++;
          $display("malformed line in downsizer_stimulus.txt: %s", line);
        end
      end
      $fclose(fd);
    end
    cmd_count = cmd_q.size();
  endtask

  // --------------------
  // Wide master
  // --------------------

  initial begin : wide_master
    aw_cmd_t     cmd;
    logic [31:0] base;
    si_strb_t    strb;
    rst_ni         = 1'b0;
    drive_aw('0, 1'b0);
    slv_w_data_i   = '0;
    slv_w_strb_i   = '0;
    slv_w_last_i   = 1'b0;
    slv_w_valid_i  = 1'b0;
    slv_b_ready_i  = 1'b1;
    mst_aw_ready_i = 1'b0;
    mst_w_ready_i  = 1'b0;
    mst_b_id_i     = '0;
    mst_b_resp_i   = '0;
    mst_b_valid_i  = 1'b0;
    load_stimulus();
    loaded = 1'b1;
    repeat (5) @(posedge clk_i);
    #2 rst_ni = 1'b1;
    @(negedge clk_i);
    if (mst_aw_valid_o !== 1'b0) report_error("mst_aw_valid_o", mst_aw_valid_o, 0);
    if (mst_w_valid_o !== 1'b0) report_error("mst_w_valid_o", mst_w_valid_o, 0);
    if (slv_w_ready_o !== 1'b0) report_error("slv_w_ready_o", slv_w_ready_o, 0);
    if (slv_aw_ready_o !== 1'b1) report_error("slv_aw_ready_o", slv_aw_ready_o, 1);
    while (cmd_q.size() > 0) begin
      cmd  = cmd_q.pop_front();
      base = wbase_q.pop_front();
      strb = wstrb_q.pop_front();
      @(posedge clk_i);
      #2 drive_aw(cmd, 1'b1);
      do @(negedge clk_i); while (slv_aw_ready_o !== 1'b1);
      @(posedge clk_i);
      #2 slv_aw_valid_i = 1'b0;
      for (int k = 0; k <= int'(cmd.len); k++) begin
        slv_w_data_i  = {base + 32'(2 * k + 1), base + 32'(2 * k)};
        slv_w_strb_i  = strb;
        slv_w_last_i  = (k == int'(cmd.len));
        slv_w_valid_i = 1'b1;
        do @(negedge clk_i); while (slv_w_ready_o !== 1'b1);
        @(posedge clk_i);
        #2;
      end
      slv_w_valid_i = 1'b0;
    end
    while (exp_w_q.size() != 0 || b_todo != 0) @(posedge clk_i);
    repeat (4) @(posedge clk_i);
    if (exp_aw_q.size() != 0) begin
      errors++;
      $display("%0d expected narrow AW bursts never appeared", exp_aw_q.size());
    end
    $display("%0d errors in %0d narrow AW, %0d narrow W and %0d B transfers",
             errors, aw_seen, w_seen, b_seen);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // Random narrow stalls, ready about three cycles in four
  initial begin : ready_driver
    forever begin
      @(posedge clk_i);
      #2 rnd = xorshift(rnd);
      mst_aw_ready_i = (rnd[3:2] != 2'b00);
      mst_w_ready_i  = (rnd[1:0] != 2'b00);
    end
  end

  // --------------------
  // Narrow slave side
  // --------------------

  always @(negedge clk_i) begin : narrow_monitor
    aw_cmd_t     exp_aw;
    logic [36:0] exp_w;
    if (rst_ni === 1'b1) begin
      if (mst_aw_valid_o && mst_w_valid_o) begin
        errors++;
        $display("error at %0t: narrow W presented while its AW is pending", $time);
      end
      if (aw_hold && mst_aw_addr_o !== held_addr)
        report_error("mst_aw_addr_o", mst_aw_addr_o, held_addr);
      if (aw_hold && mst_aw_len_o !== held_len)
        report_error("mst_aw_len_o", mst_aw_len_o, held_len);
      if (w_hold && mst_w_data_o !== held_data)
        report_error("mst_w_data_o", mst_w_data_o, held_data);
      aw_hold   = mst_aw_valid_o && !mst_aw_ready_i;
      held_addr = mst_aw_addr_o;
      held_len  = mst_aw_len_o;
      w_hold    = mst_w_valid_o && !mst_w_ready_i;
      held_data = mst_w_data_o;
      if (mst_aw_valid_o && mst_aw_ready_i) begin
        aw_seen++;
        b_id = mst_aw_id_o;
        if (exp_aw_q.size() == 0) begin
          errors++;
          $display("error at %0t: narrow AW burst that was not expected", $time);
        end else begin
          exp_aw = exp_aw_q.pop_front();
          if (mst_aw_id_o !== exp_aw.id) report_error("mst_aw_id_o", mst_aw_id_o, exp_aw.id);
          if (mst_aw_addr_o !== exp_aw.addr)
            report_error("mst_aw_addr_o", mst_aw_addr_o, exp_aw.addr);
          if (mst_aw_len_o !== exp_aw.len)
            report_error("mst_aw_len_o", mst_aw_len_o, exp_aw.len);
          if (mst_aw_size_o !== exp_aw.size)
            report_error("mst_aw_size_o", mst_aw_size_o, exp_aw.size);
          if (mst_aw_burst_o !== exp_aw.burst)
            report_error("mst_aw_burst_o", mst_aw_burst_o, exp_aw.burst);
          if (mst_aw_cache_o !== exp_aw.cache)
            report_error("mst_aw_cache_o", mst_aw_cache_o, exp_aw.cache);
        end
      end
      if (mst_w_valid_o && mst_w_ready_i) begin
        w_seen++;
        if (mst_w_last_o) b_todo++;
        if (exp_w_q.size() == 0) begin
          errors++;
          $display("error at %0t: narrow W beat that was not expected", $time);
        end else begin
          exp_w = exp_w_q.pop_front();
          if (mst_w_data_o !== exp_w[36:5])
            report_error("mst_w_data_o", mst_w_data_o, exp_w[36:5]);
          if (mst_w_strb_o !== exp_w[4:1])
            report_error("mst_w_strb_o", mst_w_strb_o, exp_w[4:1]);
          if (mst_w_last_o !== exp_w[0])
            report_error("mst_w_last_o", mst_w_last_o, exp_w[0]);
        end
      end
    end
  end

  // One B response per narrow burst, checked on the wide side
  initial begin : b_responder
    forever begin
      @(posedge clk_i);
      #2;
      if (b_todo > 0) begin
        b_todo--;
        mst_b_id_i    = b_id;
        mst_b_resp_i  = resp_t'(b_seen);
        mst_b_valid_i = 1'b1;
        @(negedge clk_i);
        if (slv_b_valid_o !== 1'b1) report_error("slv_b_valid_o", slv_b_valid_o, 1);
        if (slv_b_id_o !== mst_b_id_i) report_error("slv_b_id_o", slv_b_id_o, mst_b_id_i);
        if (slv_b_resp_o !== mst_b_resp_i)
          report_error("slv_b_resp_o", slv_b_resp_o, mst_b_resp_i);
        if (mst_b_ready_o !== 1'b1) report_error("mst_b_ready_o", mst_b_ready_o, 1);
        b_seen++;
        @(posedge clk_i);
        #2 mst_b_valid_i = 1'b0;
      end
    end
  end

  initial begin : watchdog
    wait (loaded);
    #((cmd_count + 1) * 2000 * clk_period);
    $display("timeout, the write traffic did not finish within %0d cycles",
             (cmd_count + 1) * 2000);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

/* axi_wr_downsizer.f */
+incdir+.
axi_proto_pkg.sv
dw_ctrl_pkg.sv
aw_planner.sv
w_lane_steer.sv
aw_issue.sv
axi_wr_downsizer.sv
tb_axi_wr_downsizer.sv

/* run.sh */
#!/bin/sh
# Compile the write downsizer testbench with Verilator and run it
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    -f axi_wr_downsizer.f --top-module tb_axi_wr_downsizer -o tb_axi_wr_downsizer &&
  ./obj_dir/tb_axi_wr_downsizer | tee /dev/stderr | grep -qx "NO ERRORS" &&
  echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }

/* downsizer_stimulus.txt */
# C id addr len size burst cache, then W base strb: wide beat k is {base+2k+1, base+2k}
# A id addr len size burst cache start stride strb: narrow AW, beat j data is start+j*stride
C 1 00001000 03 3 1 0
W 10000000 ff
A 1 00001000 03 3 1 0 10000000 2 f
C 2 00002004 00 2 1 2
W 20000000 f0
A 2 00002004 00 2 1 2 20000001 1 f
C 3 00003000 03 3 1 2
W 30000000 ff
A 3 00003000 07 2 1 2 30000000 1 f
C 4 00004004 01 3 1 3
W 40000000 ff
A 4 00004004 02 2 1 3 40000001 1 f
C 5 00005000 c8 3 1 2
W 50000000 ff
A 5 00005000 ff 2 1 2 50000000 1 f
A 5 00005400 91 2 1 2 50000100 1 f
C 6 0000600c 02 3 1 2
W 60000000 ff
A 6 0000600c 04 2 1 2 60000001 1 f
